//--- compile.f
hdl/ts_pkg.sv
hdl/srv_pkg.sv
hdl/ts_packet_admit.sv
hdl/ts_byte_fifo.sv
hdl/ts_null_server.sv
hdl/ts_vid_server.sv
tb/tb_clock_gen.sv
tb/tb_ts_vid_server.sv

//--- hdl/srv_pkg.sv
/*
 * Video server sizing: byte buffer depth, watermarks, statistics counter
 * width and the output FSM state encoding.
 */
package srv_pkg;
    import ts_pkg::*;

    // ------------------------------------------------------------------
    // byte buffer
    // ------------------------------------------------------------------

    // buffer size in bytes, power of two so pointers wrap on their own
    localparam int buf_depth = 1024;
    localparam int buf_addr_w = $clog2(buf_depth);

    // fill level, one bit wider than the address to reach buf_depth
    typedef logic [buf_addr_w:0] buf_level_t;

    // below two packets the server inserts nulls
    localparam buf_level_t buf_low_mark = buf_level_t'(2 * ts_packet_bytes);

    // room for one more whole packet only below this level
    localparam buf_level_t buf_full_mark = buf_level_t'(buf_depth - ts_packet_bytes);

    // ------------------------------------------------------------------
    // statistics and server FSM
    // ------------------------------------------------------------------

    // drop and null counters, wrap at 256
    typedef logic [7:0] stat_cnt_t;

    // null header covers positions 1 to 3
    typedef enum logic [2:0] {
        srv_idle,
        srv_null_hdr,
        srv_null_payload,
        srv_serve_vid,
        srv_align
    } srv_state_t;

endpackage

//--- hdl/ts_byte_fifo.sv
/*
 * Single clock show-ahead byte buffer between admission and the server.
 * head is the oldest byte, valid whenever empty is low. Also reports the
 * fill level against the low and full marks.
 */
module ts_byte_fifo
    import ts_pkg::*;
    import srv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_b,
    input  logic     wr_en,
    input  ts_byte_t wr_data,
    input  logic     rd_en,
    output ts_byte_t head,
    output logic     level_low,
    output logic     buf_full,
    output logic     empty
);

    ts_byte_t              mem [buf_depth];
    logic [buf_addr_w-1:0] wr_ptr;
    logic [buf_addr_w-1:0] rd_ptr;
    buf_level_t            level;

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // show ahead
    assign head = mem[rd_ptr];

    // ------------------------------------------------------------------
    // pointers and level
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            level_low <= 1'b1;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves level as is
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            // one cycle behind level
            level_low <= (level < buf_low_mark);
        end
    end

    assign empty    = (level == '0);
    assign buf_full = (level >= buf_full_mark);

    // admission must never overrun, server must never underrun
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_b)
        !(wr_en && level == buf_level_t'(buf_depth)));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_b)
        !(rd_en && empty));

endmodule

//--- hdl/ts_null_server.sv
/*
 * Output FSM of the video server. Sends one byte per tx_ready cycle,
 * either buffered video packets or generated null packets when the buffer
 * runs low. Discards buffered bytes until a sync byte heads the buffer.
 */
module ts_null_server
    import ts_pkg::*;
    import srv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_b,
    input  logic      tx_ready,
    input  ts_byte_t  head,
    input  logic      level_low,
    input  logic      empty,
    output logic      rd_en,
    output ts_byte_t  ts_data_out,
    output logic      ts_data_vld,
    output logic      ts_sync,
    output logic      ts_null_out,
    output stat_cnt_t null_insert_cnt
);

    srv_state_t state;
    // position of the byte presented now
    ts_pos_t    pos;
    // null packet started last cycle
    logic       null_start;
    logic       head_is_sync;
    // idle cycle that really starts a packet
    logic       pkt_start;
    logic       null_sel;

    assign head_is_sync = (head == ts_sync_byte);
    assign pkt_start    = level_low | head_is_sync;

    // ------------------------------------------------------------------
    // output side, combinational from state and head
    // ------------------------------------------------------------------

    // misaligned idle cycle counts as alignment, nothing shown
    always_comb begin
        case (state)
            srv_idle:  ts_data_vld = tx_ready & pkt_start;
            srv_align: ts_data_vld = 1'b0;
            default:   ts_data_vld = tx_ready;
        endcase
    end

    assign null_sel = (state == srv_null_hdr) | (state == srv_null_payload) |
                      ((state == srv_idle) & level_low);

    assign ts_null_out = ts_data_vld & null_sel;
    assign ts_sync     = ts_data_vld & (state == srv_idle);

    always_comb begin
        case (state)
            srv_idle:         ts_data_out = level_low ? ts_sync_byte : head;
            srv_null_hdr: begin
                if (pos == ts_pos_t'(1)) begin
                    ts_data_out = ts_null_hdr1;
                end else if (pos == ts_pos_t'(2)) begin
                    ts_data_out = ts_null_hdr2;
                end else begin
                    ts_data_out = ts_null_hdr3;
                end
            end
            srv_null_payload: ts_data_out = ts_null_fill;
            default:          ts_data_out = head;
        endcase
    end

    // video bytes on transfer, align discards up to the next sync
    assign rd_en = tx_ready &
                   (((state == srv_idle) & ~level_low & head_is_sync) |
                    (state == srv_serve_vid) |
                    ((state == srv_align) & ~empty & ~head_is_sync));

    // ------------------------------------------------------------------
    // FSM, everything holds while tx_ready is low
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state           <= srv_idle;
            pos             <= '0;
            null_start      <= 1'b0;
            null_insert_cnt <= '0;
        end else begin
            null_start <= 1'b0;
            if (null_start) begin
                null_insert_cnt <= null_insert_cnt + 1'b1;
            end
            if (tx_ready) begin
                case (state)
                    srv_idle: begin
                        if (level_low) begin
                            state      <= srv_null_hdr;
                            pos        <= ts_pos_t'(1);
                            null_start <= 1'b1;
                        end else if (head_is_sync) begin
                            state <= srv_serve_vid;
                            pos   <= ts_pos_t'(1);
                        end else begin
                            state <= srv_align;
                        end
                    end
                    srv_null_hdr: begin
                        pos <= pos + 1'b1;
                        if (pos == ts_pos_t'(3)) begin
                            state <= srv_null_payload;
                        end
                    end
                    srv_null_payload, srv_serve_vid: begin
                        if (pos == ts_pos_t'(ts_packet_bytes - 1)) begin
                            state <= srv_idle;
                            pos   <= '0;
                        end else begin
                            pos <= pos + 1'b1;
                        end
                    end
                    srv_align: begin
                        if (head_is_sync) begin
                            state <= srv_idle;
                        end
                    end
                    default: state <= srv_idle;
                endcase
            end
        end
    end

    // every packet start carries the sync byte, from buffer or generator
    a_sync_byte: assert property (@(posedge clk) disable iff (!rst_b)
        ts_sync |-> ts_data_vld && ts_data_out == ts_sync_byte);

    // a null packet never consumes buffered video
    a_null_no_read: assert property (@(posedge clk) disable iff (!rst_b)
        ts_null_out |-> !rd_en);

endmodule

//--- hdl/ts_packet_admit.sv
/*
 * Input stage of the video server. Tracks the byte position of the
 * incoming TS stream and lets whole packets into the buffer, or drops
 * them whole when the buffer has no room, counting the drops.
 */
module ts_packet_admit
    import ts_pkg::*;
    import srv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_b,
    input  ts_byte_t  vid_data,
    input  logic      vid_data_vld,
    input  logic      buf_full,
    output logic      wr_en,
    output ts_byte_t  wr_data,
    output stat_cnt_t vid_drop_cnt
);

    // position of the next strobed byte
    ts_pos_t pos;
    // current packet goes into the buffer
    logic    admit_en;
    // one cycle flag, packet start seen while not admitting
    logic    drop_seen;

    // ------------------------------------------------------------------
    // position, admission and drop count
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            pos          <= '0;
            admit_en     <= 1'b0;
            drop_seen    <= 1'b0;
            vid_drop_cnt <= '0;
        end else begin
            drop_seen <= vid_data_vld & ~admit_en & (pos == '0);
            if (drop_seen) begin
                vid_drop_cnt <= vid_drop_cnt + 1'b1;
            end
            if (vid_data_vld) begin
                if (pos == ts_pos_t'(ts_packet_bytes - 1)) begin
                    pos <= '0;
                    // decide for the next packet at the last byte
                    admit_en <= ~buf_full;
                end else begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

    // write strobe only inside admitted packets
    assign wr_en   = vid_data_vld & admit_en;
    assign wr_data = vid_data;

    // position must wrap before a full packet length
    a_pos_range: assert property (@(posedge clk) disable iff (!rst_b)
        pos < ts_pos_t'(ts_packet_bytes));

endmodule

//--- hdl/ts_pkg.sv
/*
 * MPEG transport stream packet format constants and byte types.
 * Imported by every stage that parses or builds TS packets.
 */
package ts_pkg;

    // ------------------------------------------------------------------
    // stream data types
    // ------------------------------------------------------------------

    // one byte of the transport stream
    typedef logic [7:0] ts_byte_t;

    // byte position inside a packet, 0 .. 187
    typedef logic [7:0] ts_pos_t;

    // ------------------------------------------------------------------
    // packet layout
    // ------------------------------------------------------------------

    // fixed TS packet length
    localparam int ts_packet_bytes = 188;

    // first byte of every packet
    localparam ts_byte_t ts_sync_byte = 8'h47;

    // null packet header after the sync byte, PID 0x1fff
    localparam ts_byte_t ts_null_hdr1 = 8'h1f;
    localparam ts_byte_t ts_null_hdr2 = 8'hff;
    // payload only, continuity counter zero
    localparam ts_byte_t ts_null_hdr3 = 8'h10;

    // stuffing for the 184 null payload bytes
    localparam ts_byte_t ts_null_fill = 8'hff;

endpackage

//--- hdl/ts_vid_server.sv
/*
 * TS video server top level. Admission, byte buffer and output server
 * in a three stage chain, all on clk.
 */
module ts_vid_server
    import ts_pkg::*;
    import srv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_b,
    input  ts_byte_t  vid_data,
    input  logic      vid_data_vld,
    input  logic      tx_ready,
    output ts_byte_t  ts_data_out,
    output logic      ts_data_vld,
    output logic      ts_sync,
    output logic      ts_null_out,
    output logic      vid_buf_empty,
    output stat_cnt_t vid_drop_cnt,
    output stat_cnt_t null_insert_cnt
);

    // ------------------------------------------------------------------
    // stage wiring
    // ------------------------------------------------------------------
    logic     wr_en;
    ts_byte_t wr_data;
    logic     rd_en;
    ts_byte_t head;
    logic     level_low;
    logic     buf_full;
    logic     empty;

    // buffer under two packets reported as empty outside
    assign vid_buf_empty = level_low;

    ts_packet_admit admit0 (
        .clk          (clk),
        .rst_b        (rst_b),
        .vid_data     (vid_data),
        .vid_data_vld (vid_data_vld),
        .buf_full     (buf_full),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .vid_drop_cnt (vid_drop_cnt)
    );

    ts_byte_fifo fifo0 (
        .clk       (clk),
        .rst_b     (rst_b),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .head      (head),
        .level_low (level_low),
        .buf_full  (buf_full),
        .empty     (empty)
    );

    ts_null_server srv0 (
        .clk             (clk),
        .rst_b           (rst_b),
        .tx_ready        (tx_ready),
        .head            (head),
        .level_low       (level_low),
        .empty           (empty),
        .rd_en           (rd_en),
        .ts_data_out     (ts_data_out),
        .ts_data_vld     (ts_data_vld),
        .ts_sync         (ts_sync),
        .ts_null_out     (ts_null_out),
        .null_insert_cnt (null_insert_cnt)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the TS video server testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Mdir obj_dir -o tb_sim \
    --top-module tb_ts_vid_server -f compile.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- tb/tb_clock_gen.sv
/*
 * Testbench clock and reset. clk has a period of 20, rst_b is held
 * low for the first 10 rising edges and released on an edge.
 */
module tb_clock_gen (
    output logic clk,
    output logic rst_b
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset for 10 cycles
    initial begin
        rst_b = 1'b0;
        repeat (10) @(posedge clk);
        rst_b <= 1'b1;
    end

endmodule

//--- tb/tb_ts_vid_server.sv
/*
 * Testbench for the TS video server. Feeds random TS packets, follows the
 * packet admission rule on its own and checks every output packet against
 * a null packet reference or the queue of admitted video bytes.
 */
module tb_ts_vid_server
    import ts_pkg::*;
    import srv_pkg::*;
();

    // rough length of all tests, the watchdog allows twice that
    localparam int stim_cycles    = 600 + 200 + 8 * ts_packet_bytes + 1500 +
                                    12 * 4 * ts_packet_bytes + 2000;
    localparam int timeout_cycles = 2 * stim_cycles + 2000;

    logic      clk;
    logic      rst_b;
    ts_byte_t  vid_data;
    logic      vid_data_vld;
    logic      tx_ready;
    ts_byte_t  ts_data_out;
    logic      ts_data_vld;
    logic      ts_sync;
    logic      ts_null_out;
    logic      vid_buf_empty;
    stat_cnt_t vid_drop_cnt;
    stat_cnt_t null_insert_cnt;

    // stimulus side and admission model
    logic [31:0] lfsr = 32'hcbe7f71b;
    ts_byte_t    pkt [ts_packet_bytes];
    ts_byte_t    exp_q [$];
    int          unread;
    int          drops;
    logic        admit_next;
    logic        tx_rand;
    int          align_before;
    // output side
    int          errors;
    int          null_seen;
    int          vid_seen;
    int          align_cycles;
    int          out_pos;
    logic        in_pkt;
    logic        pkt_null;

    tb_clock_gen clk0 (
        .clk   (clk),
        .rst_b (rst_b)
    );

    ts_vid_server dut0 (
        .clk             (clk),
        .rst_b           (rst_b),
        .vid_data        (vid_data),
        .vid_data_vld    (vid_data_vld),
        .tx_ready        (tx_ready),
        .ts_data_out     (ts_data_out),
        .ts_data_vld     (ts_data_vld),
        .ts_sync         (ts_sync),
        .ts_null_out     (ts_null_out),
        .vid_buf_empty   (vid_buf_empty),
        .vid_drop_cnt    (vid_drop_cnt),
        .null_insert_cnt (null_insert_cnt)
    );

    // ------------------------------------------------------------------
    // random source and reference
    // ------------------------------------------------------------------

    // fibonacci lfsr, taps 32 22 2 1, one step per bit returned
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // random byte, never a sync byte
    function automatic ts_byte_t rand_byte();
        ts_byte_t b;
        b = ts_byte_t'(next_bits(8));
        if (b == 8'h47) begin
            b = 8'h46;
        end
        return b;
    endfunction

    // null packet per ISO 13818-1, PID 0x1fff, stuffed payload
    function automatic ts_byte_t null_ref(input int pos);
        case (pos)
            0:       return 8'h47;
            1:       return 8'h1f;
            2:       return 8'hff;
            3:       return 8'h10;
            default: return 8'hff;
        endcase
    endfunction

    task automatic check(input string name, input ts_byte_t got, input ts_byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("failure: %s at %0t", what, $time);
    endtask

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------

    // one clock, books a video byte just sent, redraws tx_ready
    task automatic tick();
        @(posedge clk);
        if (ts_data_vld && !ts_null_out) begin
            unread--;
        end
        if (tx_rand) begin
            // high three cycles in four
            tx_ready <= (next_bits(2) != 32'd0);
        end
    endtask

    task automatic idle(input int n);
        vid_data_vld <= 1'b0;
        repeat (n) tick();
    endtask

    // PID stays below 0x1000, bad packets lack the sync byte
    task automatic make_packet(input logic good);
        pkt[0] = good ? ts_sync_byte : 8'hb8;
        pkt[1] = rand_byte() & 8'h0f;
        for (int i = 2; i < ts_packet_bytes; i++) begin
            pkt[i] = rand_byte();
        end
    endtask

    // admission decided at the previous packet's last byte
    task automatic feed_packet(input logic good, input logic gaps);
        logic admit_cur;
        make_packet(good);
        admit_cur = admit_next;
        if (!admit_cur) begin
            drops++;
        end else if (good) begin
            for (int i = 0; i < ts_packet_bytes; i++) begin
                exp_q.push_back(pkt[i]);
            end
        end
        for (int i = 0; i < ts_packet_bytes; i++) begin
            // gaps leave about one strobe in four
            while (gaps && next_bits(2) != 32'd0) begin
                vid_data_vld <= 1'b0;
                tick();
            end
            vid_data     <= pkt[i];
            vid_data_vld <= 1'b1;
            if (i == ts_packet_bytes - 1) begin
                admit_next = (unread < int'(buf_full_mark));
            end
            if (admit_cur) begin
                unread++;
            end
            tick();
        end
    endtask

    // ------------------------------------------------------------------
    // output packet checker
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_b) begin
            if (dut0.srv0.state == srv_align) begin
                align_cycles++;
                if (ts_data_vld) begin
                    report("byte presented while the server aligns");
                end
            end
            if (ts_data_vld) begin
                if (ts_sync) begin
                    if (in_pkt) begin
                        report("packet start before the previous packet ended");
                    end
                    in_pkt   = 1'b1;
                    out_pos  = 0;
                    pkt_null = ts_null_out;
                    if (!pkt_null && exp_q.size() < ts_packet_bytes) begin
                        report("video packet sent with no admitted packet pending");
                    end
                end
                if (!in_pkt) begin
                    report("output byte outside a packet");
                end else begin
                    check("ts_null_out", ts_byte_t'(ts_null_out), ts_byte_t'(pkt_null));
                    if (pkt_null) begin
                        check("ts_data_out", ts_data_out, null_ref(out_pos));
                    end else if (exp_q.size() > 0) begin
                        check("ts_data_out", ts_data_out, exp_q.pop_front());
                    end
                    out_pos++;
                    if (out_pos == ts_packet_bytes) begin
                        in_pkt = 1'b0;
                        if (pkt_null) begin
                            null_seen++;
                            check("null_insert_cnt", null_insert_cnt, ts_byte_t'(null_seen));
                        end else begin
                            vid_seen++;
                        end
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        vid_data     = '0;
        vid_data_vld = 1'b0;
        tx_ready     = 1'b0;
        tx_rand      = 1'b0;
        unread       = 0;
        drops        = 0;
        admit_next   = 1'b0;
        errors       = 0;
        null_seen    = 0;
        vid_seen     = 0;
        align_cycles = 0;
        out_pos      = 0;
        in_pkt       = 1'b0;
        pkt_null     = 1'b0;
        wait (rst_b);
        tick();

        // no input, nulls only
        tx_rand = 1'b1;
        idle(600);
        if (null_seen == 0) begin
            report("no null packet seen without input");
        end

        // first packet after reset is dropped
        tx_rand = 1'b0;
        tx_ready <= 1'b1;
        feed_packet(1'b1, 1'b0);
        idle(20);
        check("vid_drop_cnt", vid_drop_cnt, 8'd1);

        // fill with the transmitter stalled
        tx_ready <= 1'b0;
        repeat (8) feed_packet(1'b1, 1'b0);
        idle(20);
        check("vid_drop_cnt", vid_drop_cnt, ts_byte_t'(drops));
        check("vid_buf_empty", ts_byte_t'(vid_buf_empty), 8'd0);
        tx_ready <= 1'b1;
        while (unread > ts_packet_bytes) begin
            tick();
        end
        idle(20);
        check("vid_buf_empty", ts_byte_t'(vid_buf_empty), 8'd1);
        if (exp_q.size() != ts_packet_bytes) begin
            report("after the drain the buffer does not hold exactly one packet");
        end

        // slow input, random transmitter
        tx_rand = 1'b1;
        repeat (6) feed_packet(1'b1, 1'b1);
        idle(20);
        check("vid_drop_cnt", vid_drop_cnt, ts_byte_t'(drops));

        // misaligned packet between good ones
        align_before = align_cycles;
        feed_packet(1'b1, 1'b1);
        feed_packet(1'b0, 1'b1);
        repeat (4) feed_packet(1'b1, 1'b1);
        idle(20);
        while (exp_q.size() > ts_packet_bytes) begin
            tick();
        end
        idle(600);
        if (align_cycles == align_before) begin
            report("server never aligned past the misaligned packet");
        end
        // last packet stays below the low mark
        if (exp_q.size() != ts_packet_bytes) begin
            report("admitted video packets missing at the output");
        end
        check("vid_drop_cnt", vid_drop_cnt, ts_byte_t'(drops));

        $display("video %0d, null %0d, drops %0d, errors %0d",
                 vid_seen, null_seen, drops, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped making progress",
                 timeout_cycles);
        $display("video %0d, null %0d, drops %0d, errors %0d",
                 vid_seen, null_seen, drops, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule
